/* filelist.f */
+incdir+.
natv_pkg.sv
natv_decode.sv
natv_sysctrl.sv
natv_gpio.sv
natv_timer.sv
ip_natv_wrapper.sv
ip_natv_wrapper_asserts.sv
tb_ip_natv_wrapper.sv

/* ip_natv_wrapper.sv */
// native-bus peripheral cluster: decoder, sysctrl, gpio and two timers
// sysctrl gathers the peripheral interrupts and drives the masked vector
`timescale 1ns/1ps

module ip_natv_wrapper #(
  parameter int GPIO_W = 8,
  parameter int TIM0_W = 32,
  parameter int TIM1_W = 16
) (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           nmi_valid_i,
  input  logic [natv_pkg::ADDR_W-1:0]    nmi_addr_i,
  input  logic [natv_pkg::DATA_W-1:0]    nmi_wdata_i,
  input  logic [natv_pkg::STRB_W-1:0]    nmi_wstrb_i,
  output logic                           nmi_ready_o,
  output logic [natv_pkg::DATA_W-1:0]    nmi_rdata_o,
  input  logic [GPIO_W-1:0]              gpio_in_i,
  output logic [GPIO_W-1:0]              gpio_out_o,
  output logic [GPIO_W-1:0]              gpio_oe_o,
  output logic [natv_pkg::IRQ_NUM-1:0]   irq_o
);

  logic [natv_pkg::REG_IDX_W-1:0] s_reg_idx;
  logic [natv_pkg::DATA_W-1:0]    s_wdata;
  logic [natv_pkg::STRB_W-1:0]    s_wstrb;
  logic s_sys_valid, s_gpio_valid, s_tim0_valid, s_tim1_valid;
  logic s_sys_ready, s_gpio_ready, s_tim0_ready, s_tim1_ready;
  logic [natv_pkg::DATA_W-1:0]    s_sys_rdata, s_gpio_rdata, s_tim0_rdata, s_tim1_rdata;
  // raw interrupt lines before masking
  logic [natv_pkg::IRQ_NUM-1:0]   s_irq_raw;

  natv_decode u_natv_decode (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .nmi_valid_i  (nmi_valid_i),
    .nmi_addr_i   (nmi_addr_i),
    .nmi_wdata_i  (nmi_wdata_i),
    .nmi_wstrb_i  (nmi_wstrb_i),
    .nmi_ready_o  (nmi_ready_o),
    .nmi_rdata_o  (nmi_rdata_o),
    .sys_ready_i  (s_sys_ready),
    .gpio_ready_i (s_gpio_ready),
    .tim0_ready_i (s_tim0_ready),
    .tim1_ready_i (s_tim1_ready),
    .sys_rdata_i  (s_sys_rdata),
    .gpio_rdata_i (s_gpio_rdata),
    .tim0_rdata_i (s_tim0_rdata),
    .tim1_rdata_i (s_tim1_rdata),
    .sys_valid_o  (s_sys_valid),
    .gpio_valid_o (s_gpio_valid),
    .tim0_valid_o (s_tim0_valid),
    .tim1_valid_o (s_tim1_valid),
    .reg_idx_o    (s_reg_idx),
    .wdata_o      (s_wdata),
    .wstrb_o      (s_wstrb)
  );

  natv_sysctrl u_natv_sysctrl (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .valid_i   (s_sys_valid),
    .reg_idx_i (s_reg_idx),
    .wdata_i   (s_wdata),
    .wstrb_i   (s_wstrb),
    .irq_raw_i (s_irq_raw),
    .ready_o   (s_sys_ready),
    .rdata_o   (s_sys_rdata),
    .irq_o     (irq_o)
  );

  natv_gpio #(
    .GPIO_W (GPIO_W)
  ) u_natv_gpio (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .valid_i    (s_gpio_valid),
    .reg_idx_i  (s_reg_idx),
    .wdata_i    (s_wdata),
    .wstrb_i    (s_wstrb),
    .gpio_in_i  (gpio_in_i),
    .ready_o    (s_gpio_ready),
    .rdata_o    (s_gpio_rdata),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .irq_o      (s_irq_raw[natv_pkg::IRQ_GPIO])
  );

  natv_timer #(
    .CNT_W (TIM0_W)
  ) u_timer0 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .valid_i   (s_tim0_valid),
    .reg_idx_i (s_reg_idx),
    .wdata_i   (s_wdata),
    .wstrb_i   (s_wstrb),
    .ready_o   (s_tim0_ready),
    .rdata_o   (s_tim0_rdata),
    .irq_o     (s_irq_raw[natv_pkg::IRQ_TIM0])
  );

  natv_timer #(
    .CNT_W (TIM1_W)
  ) u_timer1 (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .valid_i   (s_tim1_valid),
    .reg_idx_i (s_reg_idx),
    .wdata_i   (s_wdata),
    .wstrb_i   (s_wstrb),
    .ready_o   (s_tim1_ready),
    .rdata_o   (s_tim1_rdata),
    .irq_o     (s_irq_raw[natv_pkg::IRQ_TIM1])
  );

endmodule

/* ip_natv_wrapper_asserts.sv */
// handshake and reset checks on the native-bus cluster
// bound into the top level of the cluster
`timescale 1ns/1ps

module ip_natv_wrapper_asserts (
  input logic                         clk_i,
  input logic                         reset_i,
  input logic                         valid_i,
  input logic                         ready_i,
  input logic [natv_pkg::IRQ_NUM-1:0] irq_i
);

  // number of failed assertions
  int unsigned fail_cnt = 0;

  // ready is a one-cycle pulse
  a_ready_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i) ready_i |=> !ready_i
  ) else begin
    fail_cnt++;
    $error("nmi_ready_o stayed high for two cycles");
  end

  a_ready_after_valid: assert property (
    @(posedge clk_i) disable iff (reset_i) ready_i |-> $past(valid_i)
  ) else begin
    fail_cnt++;
    $error("nmi_ready_o rose without a request in the cycle before");
  end

  // registers are cleared after the first reset edge
  a_reset_quiet: assert property (
    @(posedge clk_i) (reset_i && $past(reset_i)) |-> (irq_i == '0 && !ready_i)
  ) else begin
    fail_cnt++;
    $error("irq_o or nmi_ready_o not zero during reset");
  end

endmodule

bind ip_natv_wrapper ip_natv_wrapper_asserts u_asserts (
  .clk_i   (clk_i),
  .reset_i (reset_i),
  .valid_i (nmi_valid_i),
  .ready_i (nmi_ready_o),
  .irq_i   (irq_o)
);

/* mmap_define.svh */
// address map of the native-bus peripheral region
// region code sits in addr[31:28], peripheral selector in addr[15:8]
`ifndef MMAP_DEFINE_SVH
`define MMAP_DEFINE_SVH

// register region
`define NATV_IP_START     4'h1

// peripheral selectors inside the region
`define NMI_SYSCTRL_START 8'h00
`define NMI_GPIO_START    8'h01
`define NMI_TIM0_START    8'h02
`define NMI_TIM1_START    8'h03

`endif

/* natv_decode.sv */
// address decoder of the native bus, one valid strobe per peripheral
// also answers accesses that hit no peripheral with a zero read
`timescale 1ns/1ps
`include "mmap_define.svh"

module natv_decode (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             nmi_valid_i,
  input  logic [natv_pkg::ADDR_W-1:0]      nmi_addr_i,
  input  logic [natv_pkg::DATA_W-1:0]      nmi_wdata_i,
  input  logic [natv_pkg::STRB_W-1:0]      nmi_wstrb_i,
  output logic                             nmi_ready_o,
  output logic [natv_pkg::DATA_W-1:0]      nmi_rdata_o,
  input  logic                             sys_ready_i,
  input  logic                             gpio_ready_i,
  input  logic                             tim0_ready_i,
  input  logic                             tim1_ready_i,
  input  logic [natv_pkg::DATA_W-1:0]      sys_rdata_i,
  input  logic [natv_pkg::DATA_W-1:0]      gpio_rdata_i,
  input  logic [natv_pkg::DATA_W-1:0]      tim0_rdata_i,
  input  logic [natv_pkg::DATA_W-1:0]      tim1_rdata_i,
  output logic                             sys_valid_o,
  output logic                             gpio_valid_o,
  output logic                             tim0_valid_o,
  output logic                             tim1_valid_o,
  output logic [natv_pkg::REG_IDX_W-1:0]   reg_idx_o,
  output logic [natv_pkg::DATA_W-1:0]      wdata_o,
  output logic [natv_pkg::STRB_W-1:0]      wstrb_o
);

  logic       region_hit;
  logic [7:0] sel;
  logic       sys_hit;
  logic       gpio_hit;
  logic       tim0_hit;
  logic       tim1_hit;
  logic       miss;
  logic       miss_ready_q;
  logic       sys_ack;
  logic       gpio_ack;
  logic       tim0_ack;
  logic       tim1_ack;

  assign region_hit = (nmi_addr_i[31:28] == `NATV_IP_START);
  assign sel        = nmi_addr_i[15:8];

  assign sys_hit  = region_hit && (sel == `NMI_SYSCTRL_START);
  assign gpio_hit = region_hit && (sel == `NMI_GPIO_START);
  assign tim0_hit = region_hit && (sel == `NMI_TIM0_START);
  assign tim1_hit = region_hit && (sel == `NMI_TIM1_START);

  assign sys_valid_o  = nmi_valid_i && sys_hit;
  assign gpio_valid_o = nmi_valid_i && gpio_hit;
  assign tim0_valid_o = nmi_valid_i && tim0_hit;
  assign tim1_valid_o = nmi_valid_i && tim1_hit;

  // shared request fields
  assign reg_idx_o = nmi_addr_i[7:2];
  assign wdata_o   = nmi_wdata_i;
  assign wstrb_o   = nmi_wstrb_i;

  // default responder, writes are dropped
  assign miss = nmi_valid_i && !(sys_hit || gpio_hit || tim0_hit || tim1_hit);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      miss_ready_q <= 1'b0;
    end else begin
      miss_ready_q <= miss && !miss_ready_q;
    end
  end

  assign sys_ack  = sys_valid_o && sys_ready_i;
  assign gpio_ack = gpio_valid_o && gpio_ready_i;
  assign tim0_ack = tim0_valid_o && tim0_ready_i;
  assign tim1_ack = tim1_valid_o && tim1_ready_i;

  assign nmi_ready_o = sys_ack | gpio_ack | tim0_ack | tim1_ack | (miss && miss_ready_q);

  assign nmi_rdata_o = ({natv_pkg::DATA_W{sys_ack}}  & sys_rdata_i)  |
                       ({natv_pkg::DATA_W{gpio_ack}} & gpio_rdata_i) |
                       ({natv_pkg::DATA_W{tim0_ack}} & tim0_rdata_i) |
                       ({natv_pkg::DATA_W{tim1_ack}} & tim1_rdata_i);

endmodule

/* natv_gpio.sv */
// gpio port with output, output-enable and synchronized input registers
// rising input edges latch flags that can raise one interrupt line
`timescale 1ns/1ps

module natv_gpio #(
  parameter int GPIO_W = 8
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             valid_i,
  input  logic [natv_pkg::REG_IDX_W-1:0]   reg_idx_i,
  input  logic [natv_pkg::DATA_W-1:0]      wdata_i,
  input  logic [natv_pkg::STRB_W-1:0]      wstrb_i,
  input  logic [GPIO_W-1:0]                gpio_in_i,
  output logic                             ready_o,
  output logic [natv_pkg::DATA_W-1:0]      rdata_o,
  output logic [GPIO_W-1:0]                gpio_out_o,
  output logic [GPIO_W-1:0]                gpio_oe_o,
  output logic                             irq_o
);

  logic                         ready_q;
  logic                         wr_en;
  logic [GPIO_W-1:0]            out_q;
  logic [GPIO_W-1:0]            oe_q;
  logic [GPIO_W-1:0]            ie_q;
  logic [GPIO_W-1:0]            rise_q;
  logic [GPIO_W-1:0]            sync1_q;
  logic [GPIO_W-1:0]            sync2_q;
  logic [GPIO_W-1:0]            prev_q;
  logic [GPIO_W-1:0]            rise_set;
  logic [GPIO_W-1:0]            rise_clr;
  logic [natv_pkg::DATA_W-1:0]  rd_word;
  logic [natv_pkg::DATA_W-1:0]  wr_word;
  logic [natv_pkg::DATA_W-1:0]  clr_word;

  assign wr_en    = valid_i && !ready_q && (|wstrb_i);
  assign wr_word  = natv_pkg::merge_bytes(rd_word, wdata_i, wstrb_i);
  // write-one-to-clear only over the strobed lanes
  assign clr_word = natv_pkg::merge_bytes('0, wdata_i, wstrb_i);

  assign rise_set = sync2_q & ~prev_q;
  assign rise_clr = (wr_en && reg_idx_i == natv_pkg::GPIO_RISE) ?
                    clr_word[GPIO_W-1:0] : '0;

  always_comb begin
    rd_word = '0;
    case (reg_idx_i)
      natv_pkg::GPIO_OUT:  rd_word[GPIO_W-1:0] = out_q;
      natv_pkg::GPIO_OE:   rd_word[GPIO_W-1:0] = oe_q;
      natv_pkg::GPIO_IN:   rd_word[GPIO_W-1:0] = sync2_q;
      natv_pkg::GPIO_RISE: rd_word[GPIO_W-1:0] = rise_q;
      natv_pkg::GPIO_IE:   rd_word[GPIO_W-1:0] = ie_q;
      default:             rd_word = '0;
    endcase
  end

  // two-flop synchronizer, prev_q holds the last synchronized value
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      sync1_q <= '0;
      sync2_q <= '0;
      prev_q  <= '0;
    end else begin
      sync1_q <= gpio_in_i;
      sync2_q <= sync1_q;
      prev_q  <= sync2_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
      out_q   <= '0;
      oe_q    <= '0;
      ie_q    <= '0;
      rise_q  <= '0;
    end else begin
      ready_q <= valid_i && !ready_q;
      // a new edge wins over a clear in the same cycle
      rise_q  <= (rise_q & ~rise_clr) | rise_set;
      if (wr_en) begin
        case (reg_idx_i)
          natv_pkg::GPIO_OUT: out_q <= wr_word[GPIO_W-1:0];
          natv_pkg::GPIO_OE:  oe_q <= wr_word[GPIO_W-1:0];
          natv_pkg::GPIO_IE:  ie_q <= wr_word[GPIO_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign ready_o    = ready_q;
  assign rdata_o    = rd_word;
  assign gpio_out_o = out_q;
  assign gpio_oe_o  = oe_q;
  assign irq_o      = |(rise_q & ie_q);

endmodule

/* natv_pkg.sv */
// bus widths, register indices and interrupt positions of the native-bus cluster
// referenced by scoped name from every RTL block and the testbench
package natv_pkg;

  localparam int ADDR_W    = 32;
  localparam int DATA_W    = 32;
  localparam int STRB_W    = 4;
  localparam int REG_IDX_W = 6;

  // sysctrl registers
  localparam logic [REG_IDX_W-1:0] SYS_ID       = 6'd0;
  localparam logic [REG_IDX_W-1:0] SYS_SCRATCH  = 6'd1;
  localparam logic [REG_IDX_W-1:0] SYS_IRQ_MASK = 6'd2;
  localparam logic [REG_IDX_W-1:0] SYS_IRQ_PEND = 6'd3;

  // gpio registers
  localparam logic [REG_IDX_W-1:0] GPIO_OUT  = 6'd0;
  localparam logic [REG_IDX_W-1:0] GPIO_OE   = 6'd1;
  localparam logic [REG_IDX_W-1:0] GPIO_IN   = 6'd2;
  localparam logic [REG_IDX_W-1:0] GPIO_RISE = 6'd3;
  localparam logic [REG_IDX_W-1:0] GPIO_IE   = 6'd4;

  // timer registers
  localparam logic [REG_IDX_W-1:0] TIM_CTRL     = 6'd0;
  localparam logic [REG_IDX_W-1:0] TIM_PRESCALE = 6'd1;
  localparam logic [REG_IDX_W-1:0] TIM_COMPARE  = 6'd2;
  localparam logic [REG_IDX_W-1:0] TIM_COUNT    = 6'd3;
  localparam logic [REG_IDX_W-1:0] TIM_STATUS   = 6'd4;

  localparam int IRQ_NUM  = 3;
  localparam int IRQ_TIM0 = 0;
  localparam int IRQ_TIM1 = 1;
  localparam int IRQ_GPIO = 2;

  localparam logic [DATA_W-1:0] SYSCTRL_ID = 32'h4e4d_0100;

  // byte lanes with a set strobe take the new word
  function automatic logic [DATA_W-1:0] merge_bytes(
    input logic [DATA_W-1:0] old_word,
    input logic [DATA_W-1:0] new_word,
    input logic [STRB_W-1:0] strb
  );
    logic [DATA_W-1:0] res;
    res = old_word;
    for (int i = 0; i < STRB_W; i++) begin
      if (strb[i]) begin
        res[i*8 +: 8] = new_word[i*8 +: 8];
      end
    end
    return res;
  endfunction

endpackage

/* natv_sysctrl.sv */
// system control block with identity, scratch and interrupt mask
// masks the raw interrupt vector gathered from the peripherals
`timescale 1ns/1ps

module natv_sysctrl (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             valid_i,
  input  logic [natv_pkg::REG_IDX_W-1:0]   reg_idx_i,
  input  logic [natv_pkg::DATA_W-1:0]      wdata_i,
  input  logic [natv_pkg::STRB_W-1:0]      wstrb_i,
  input  logic [natv_pkg::IRQ_NUM-1:0]     irq_raw_i,
  output logic                             ready_o,
  output logic [natv_pkg::DATA_W-1:0]      rdata_o,
  output logic [natv_pkg::IRQ_NUM-1:0]     irq_o
);

  logic                          ready_q;
  logic                          wr_en;
  logic [natv_pkg::DATA_W-1:0]   scratch_q;
  logic [natv_pkg::IRQ_NUM-1:0]  mask_q;
  logic [natv_pkg::DATA_W-1:0]   rd_word;
  logic [natv_pkg::DATA_W-1:0]   wr_word;

  assign wr_en   = valid_i && !ready_q && (|wstrb_i);
  assign wr_word = natv_pkg::merge_bytes(rd_word, wdata_i, wstrb_i);

  always_comb begin
    rd_word = '0;
    case (reg_idx_i)
      natv_pkg::SYS_ID:       rd_word = natv_pkg::SYSCTRL_ID;
      natv_pkg::SYS_SCRATCH:  rd_word = scratch_q;
      natv_pkg::SYS_IRQ_MASK: rd_word[natv_pkg::IRQ_NUM-1:0] = mask_q;
      // pending shows the raw lines before masking
      natv_pkg::SYS_IRQ_PEND: rd_word[natv_pkg::IRQ_NUM-1:0] = irq_raw_i;
      default:                rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q   <= 1'b0;
      scratch_q <= '0;
      mask_q    <= '0;
    end else begin
      ready_q <= valid_i && !ready_q;
      if (wr_en) begin
        case (reg_idx_i)
          natv_pkg::SYS_SCRATCH:  scratch_q <= wr_word;
          natv_pkg::SYS_IRQ_MASK: mask_q <= wr_word[natv_pkg::IRQ_NUM-1:0];
          default: ;
        endcase
      end
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rd_word;
  assign irq_o   = irq_raw_i & mask_q;

endmodule

/* natv_timer.sv */
// prescaled timer with a compare match and a sticky match flag
// the count wraps to zero on a match, the flag is cleared by writing one
`timescale 1ns/1ps

module natv_timer #(
  parameter int CNT_W = 32
) (
  input  logic                             clk_i,
  input  logic                             reset_i,
  input  logic                             valid_i,
  input  logic [natv_pkg::REG_IDX_W-1:0]   reg_idx_i,
  input  logic [natv_pkg::DATA_W-1:0]      wdata_i,
  input  logic [natv_pkg::STRB_W-1:0]      wstrb_i,
  output logic                             ready_o,
  output logic [natv_pkg::DATA_W-1:0]      rdata_o,
  output logic                             irq_o
);

  logic                         ready_q;
  logic                         wr_en;
  logic [1:0]                   ctrl_q;
  logic [CNT_W-1:0]             pre_q;
  logic [CNT_W-1:0]             pre_cnt_q;
  logic [CNT_W-1:0]             cmp_q;
  logic [CNT_W-1:0]             cnt_q;
  logic                         flag_q;
  logic                         pre_done;
  logic                         tick;
  logic                         hit;
  logic                         flag_clr;
  logic [natv_pkg::DATA_W-1:0]  rd_word;
  logic [natv_pkg::DATA_W-1:0]  wr_word;

  assign wr_en   = valid_i && !ready_q && (|wstrb_i);
  assign wr_word = natv_pkg::merge_bytes(rd_word, wdata_i, wstrb_i);

  // ctrl[0] enables counting
  assign pre_done = (pre_cnt_q == pre_q);
  assign tick     = ctrl_q[0] && pre_done;
  assign hit      = (cnt_q == cmp_q);
  assign flag_clr = wr_en && (reg_idx_i == natv_pkg::TIM_STATUS) && wstrb_i[0] && wdata_i[0];

  always_comb begin
    rd_word = '0;
    case (reg_idx_i)
      natv_pkg::TIM_CTRL:     rd_word[1:0] = ctrl_q;
      natv_pkg::TIM_PRESCALE: rd_word[CNT_W-1:0] = pre_q;
      natv_pkg::TIM_COMPARE:  rd_word[CNT_W-1:0] = cmp_q;
      natv_pkg::TIM_COUNT:    rd_word[CNT_W-1:0] = cnt_q;
      natv_pkg::TIM_STATUS:   rd_word[0] = flag_q;
      default:                rd_word = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q   <= 1'b0;
      ctrl_q    <= '0;
      pre_q     <= '0;
      pre_cnt_q <= '0;
      cmp_q     <= '0;
      cnt_q     <= '0;
      flag_q    <= 1'b0;
    end else begin
      ready_q <= valid_i && !ready_q;
      if (ctrl_q[0]) begin
        pre_cnt_q <= pre_done ? '0 : pre_cnt_q + 1'b1;
      end
      if (tick) begin
        cnt_q <= hit ? '0 : cnt_q + 1'b1;
      end
      // set has priority over a clear in the same cycle
      flag_q <= (flag_q && !flag_clr) || (tick && hit);
      // register writes override the counting above
      if (wr_en) begin
        case (reg_idx_i)
          natv_pkg::TIM_CTRL: ctrl_q <= wr_word[1:0];
          natv_pkg::TIM_PRESCALE: begin
            pre_q     <= wr_word[CNT_W-1:0];
            pre_cnt_q <= '0;
          end
          natv_pkg::TIM_COMPARE: cmp_q <= wr_word[CNT_W-1:0];
          natv_pkg::TIM_COUNT:   cnt_q <= wr_word[CNT_W-1:0];
          default: ;
        endcase
      end
    end
  end

  assign ready_o = ready_q;
  assign rdata_o = rd_word;
  // ctrl[1] enables the interrupt
  assign irq_o   = flag_q && ctrl_q[1];

endmodule

/* tb_ip_natv_wrapper.sv */
// testbench of the native-bus peripheral cluster
// runs a table of bus accesses and checks read data, interrupts and gpio pins
`timescale 1ns/1ps
`include "mmap_define.svh"

module tb_ip_natv_wrapper;

  localparam int GPIO_W       = 8;
  localparam int TIM0_W       = 32;
  localparam int TIM1_W       = 16;
  localparam int RESET_CYCLES = 10;
  localparam int READY_TRIES  = 8;

  typedef struct packed {
    logic [natv_pkg::ADDR_W-1:0]  addr;
    logic [natv_pkg::DATA_W-1:0]  wdata;
    logic [natv_pkg::STRB_W-1:0]  wstrb;
    logic [7:0]                   wait_cyc;
    logic                         check_rd;
    logic [natv_pkg::DATA_W-1:0]  exp_rdata;
    logic [natv_pkg::IRQ_NUM-1:0] exp_irq;
    logic [GPIO_W-1:0]            gpio_in;
    logic [GPIO_W-1:0]            exp_out;
    logic [GPIO_W-1:0]            exp_oe;
  } row_t;

  logic                         clk_i;
  logic                         reset_i;
  logic                         nmi_valid_i;
  logic [natv_pkg::ADDR_W-1:0]  nmi_addr_i;
  logic [natv_pkg::DATA_W-1:0]  nmi_wdata_i;
  logic [natv_pkg::STRB_W-1:0]  nmi_wstrb_i;
  logic                         nmi_ready_o;
  logic [natv_pkg::DATA_W-1:0]  nmi_rdata_o;
  logic [GPIO_W-1:0]            gpio_in_i;
  logic [GPIO_W-1:0]            gpio_out_o;
  logic [GPIO_W-1:0]            gpio_oe_o;
  logic [natv_pkg::IRQ_NUM-1:0] irq_o;

  row_t                         rows[$];
  int                           errors = 0;
  int                           checks = 0;
  int unsigned                  budget = 0;
  int unsigned                  cycles = 0;
  int unsigned                  limit = 32'hffff_ffff;
  // reference model state while the table is built
  logic [natv_pkg::DATA_W-1:0]  scratch_m;
  logic [natv_pkg::DATA_W-1:0]  out_m;
  logic [natv_pkg::DATA_W-1:0]  oe_m;
  logic [natv_pkg::IRQ_NUM-1:0] irq_m;
  logic [GPIO_W-1:0]            gin_m;

  ip_natv_wrapper #(
    .GPIO_W (GPIO_W),
    .TIM0_W (TIM0_W),
    .TIM1_W (TIM1_W)
  ) dut0 (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .nmi_valid_i (nmi_valid_i),
    .nmi_addr_i  (nmi_addr_i),
    .nmi_wdata_i (nmi_wdata_i),
    .nmi_wstrb_i (nmi_wstrb_i),
    .nmi_ready_o (nmi_ready_o),
    .nmi_rdata_o (nmi_rdata_o),
    .gpio_in_i   (gpio_in_i),
    .gpio_out_o  (gpio_out_o),
    .gpio_oe_o   (gpio_oe_o),
    .irq_o       (irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: the run did not finish within %0d cycles", limit);
      $display("Test FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // byte lanes with a strobe bit set take the new data
  function automatic logic [natv_pkg::DATA_W-1:0] strobe_write(
    input logic [natv_pkg::DATA_W-1:0] old_w,
    input logic [natv_pkg::DATA_W-1:0] new_w,
    input logic [natv_pkg::STRB_W-1:0] strb
  );
    logic [natv_pkg::DATA_W-1:0] m;
    for (int i = 0; i < natv_pkg::STRB_W; i++) begin
      m[i*8 +: 8] = {8{strb[i]}};
    end
    return (old_w & ~m) | (new_w & m);
  endfunction

  function automatic logic [natv_pkg::DATA_W-1:0] keep_low(
    input logic [natv_pkg::DATA_W-1:0] word,
    input int w
  );
    logic [natv_pkg::DATA_W-1:0] ones;
    ones = '1;
    return word & ~(ones << w);
  endfunction

  function automatic logic [31:0] reg_addr(input logic [7:0] sel, input logic [5:0] idx);
    return {`NATV_IP_START, 12'h000, sel, idx, 2'b00};
  endfunction

  task automatic add_row(input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] wstrb, input int wait_cyc,
                         input logic check_rd, input logic [31:0] exp_rdata);
    row_t r;
    r = '{addr, wdata, wstrb, 8'(wait_cyc), check_rd, exp_rdata, irq_m, gin_m,
          out_m[GPIO_W-1:0], oe_m[GPIO_W-1:0]};
    rows.push_back(r);
    budget += 3 + wait_cyc;
  endtask

  task automatic write_row(input logic [31:0] addr, input logic [31:0] wdata,
                           input logic [3:0] wstrb, input int wait_cyc);
    add_row(addr, wdata, wstrb, wait_cyc, 1'b0, '0);
  endtask

  task automatic read_row(input logic [31:0] addr, input logic [31:0] exp, input int wait_cyc);
    add_row(addr, '0, '0, wait_cyc, 1'b1, exp);
  endtask

  task automatic build_table();
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r3;
    logic [31:0] r4;
    logic [31:0] r5;
    logic [31:0] r6;
    r0 = xorshift(32'h5a11_8126);
    r1 = xorshift(r0);
    r2 = xorshift(r1);
    r3 = xorshift(r2);
    r4 = xorshift(r3);
    r5 = xorshift(r4);
    r6 = xorshift(r5);
    scratch_m = '0;
    out_m     = '0;
    oe_m      = '0;
    irq_m     = '0;
    gin_m     = '0;
    read_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_ID), natv_pkg::SYSCTRL_ID, 0);
    // scratch with partial strobes
    scratch_m = strobe_write(scratch_m, r0, 4'hf);
    write_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_SCRATCH), r0, 4'hf, 0);
    scratch_m = strobe_write(scratch_m, r1, 4'b0101);
    write_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_SCRATCH), r1, 4'b0101, 0);
    read_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_SCRATCH), scratch_m, 0);
    scratch_m = strobe_write(scratch_m, r2, 4'b1000);
    write_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_SCRATCH), r2, 4'b1000, 0);
    read_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_SCRATCH), scratch_m, 0);
    // writes to another region and to an unused selector leave scratch alone
    add_row(32'h2000_0004, r3, 4'hf, 0, 1'b1, '0);
    add_row(reg_addr(8'h07, natv_pkg::SYS_SCRATCH), ~r3, 4'hf, 0, 1'b1, '0);
    read_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_SCRATCH), scratch_m, 0);
    write_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_IRQ_MASK), 32'h7, 4'hf, 0);
    // lane 1 lies above the port width
    out_m = keep_low(strobe_write(out_m, r4, 4'b0010), GPIO_W);
    write_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_OUT), r4, 4'b0010, 0);
    out_m = keep_low(strobe_write(out_m, r4, 4'hf), GPIO_W);
    write_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_OUT), r4, 4'hf, 0);
    read_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_OUT), out_m, 0);
    oe_m = keep_low(strobe_write(oe_m, r5, 4'b0001), GPIO_W);
    write_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_OE), r5, 4'b0001, 0);
    read_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_OE), oe_m, 0);
    write_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_IE), 32'hff, 4'hf, 0);
    // input rises from zero and needs a few cycles to pass the synchronizer
    gin_m = r6[GPIO_W-1:0] | 1'b1;
    irq_m = natv_pkg::IRQ_NUM'(1) << natv_pkg::IRQ_GPIO;
    read_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_IE), 32'hff, 4);
    read_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_IN), gin_m, 0);
    read_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_RISE), gin_m, 0);
    irq_m = '0;
    write_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_RISE), gin_m, 4'hf, 0);
    read_row(reg_addr(`NMI_GPIO_START, natv_pkg::GPIO_RISE), '0, 0);
    // timer 0 matches after (5+1)*(2+1) enabled cycles
    write_row(reg_addr(`NMI_TIM0_START, natv_pkg::TIM_PRESCALE), 32'd2, 4'hf, 0);
    write_row(reg_addr(`NMI_TIM0_START, natv_pkg::TIM_COMPARE), 32'd5, 4'hf, 0);
    irq_m = natv_pkg::IRQ_NUM'(1) << natv_pkg::IRQ_TIM0;
    write_row(reg_addr(`NMI_TIM0_START, natv_pkg::TIM_CTRL), 32'h3, 4'hf, 6 * 3 + 6);
    read_row(reg_addr(`NMI_TIM0_START, natv_pkg::TIM_STATUS), 32'h1, 0);
    write_row(reg_addr(`NMI_TIM0_START, natv_pkg::TIM_CTRL), 32'h2, 4'hf, 0);
    irq_m = '0;
    write_row(reg_addr(`NMI_TIM0_START, natv_pkg::TIM_STATUS), 32'h1, 4'hf, 0);
    read_row(reg_addr(`NMI_TIM0_START, natv_pkg::TIM_STATUS), '0, 0);
    // narrow timer 1
    write_row(reg_addr(`NMI_TIM1_START, natv_pkg::TIM_COMPARE), 32'h0001_2345, 4'hf, 0);
    read_row(reg_addr(`NMI_TIM1_START, natv_pkg::TIM_COMPARE),
             keep_low(32'h0001_2345, TIM1_W), 0);
    write_row(reg_addr(`NMI_TIM1_START, natv_pkg::TIM_COMPARE), 32'd3, 4'hf, 0);
    irq_m = natv_pkg::IRQ_NUM'(1) << natv_pkg::IRQ_TIM1;
    write_row(reg_addr(`NMI_TIM1_START, natv_pkg::TIM_CTRL), 32'h3, 4'hf, 4 + 6);
    // masked line still shows as pending
    irq_m = '0;
    write_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_IRQ_MASK),
              ~(32'h1 << natv_pkg::IRQ_TIM1), 4'hf, 0);
    read_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_IRQ_PEND),
             32'h1 << natv_pkg::IRQ_TIM1, 0);
    irq_m = natv_pkg::IRQ_NUM'(1) << natv_pkg::IRQ_TIM1;
    write_row(reg_addr(`NMI_SYSCTRL_START, natv_pkg::SYS_IRQ_MASK), 32'h7, 4'hf, 0);
  endtask

  task automatic check_rdata(input logic [natv_pkg::DATA_W-1:0] got,
                             input logic [natv_pkg::DATA_W-1:0] exp, input int row);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: row %0d rdata %h, expected %h", $time, row, got, exp);
    end
  endtask

  task automatic check_irq(input logic [natv_pkg::IRQ_NUM-1:0] got,
                           input logic [natv_pkg::IRQ_NUM-1:0] exp, input int row);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: row %0d irq_o %b, expected %b", $time, row, got, exp);
    end
  endtask

  task automatic check_pins(input logic [GPIO_W-1:0] got, input logic [GPIO_W-1:0] exp,
                            input string name, input int row);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error at %0t: row %0d %s %h, expected %h", $time, row, name, got, exp);
    end
  endtask

  // valid stays up through the ready cycle and drops one cycle later
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output logic [31:0] rdata,
                            output logic got_ready);
    nmi_addr_i  = addr;
    nmi_wdata_i = wdata;
    nmi_wstrb_i = wstrb;
    nmi_valid_i = 1'b1;
    got_ready   = 1'b0;
    rdata       = '0;
    for (int i = 0; i < READY_TRIES && !got_ready; i++) begin
      @(posedge clk_i);
      #1;
      if (nmi_ready_o) begin
        got_ready = 1'b1;
        rdata     = nmi_rdata_o;
      end
    end
    @(posedge clk_i);
    #1;
    nmi_valid_i = 1'b0;
    nmi_wstrb_i = '0;
  endtask

  initial begin
    row_t        r;
    logic [31:0] rdata;
    logic        got;
    int          row_err;
    reset_i     = 1'b1;
    nmi_valid_i = 1'b0;
    nmi_addr_i  = '0;
    nmi_wdata_i = '0;
    nmi_wstrb_i = '0;
    gpio_in_i   = '0;
    build_table();
    limit = 2 * budget;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    for (int i = 0; i < rows.size(); i++) begin
      r       = rows[i];
      row_err = errors;
      @(posedge clk_i);
      #1;
      gpio_in_i = r.gpio_in;
      bus_access(r.addr, r.wdata, r.wstrb, rdata, got);
      if (!got) begin
        errors++;
        $display("row %0d: the DUT gave no ready for the access at address %h", i, r.addr);
      end else if (r.check_rd) begin
        check_rdata(rdata, r.exp_rdata, i);
      end
      repeat (r.wait_cyc) begin
        @(posedge clk_i);
        #1;
      end
      check_irq(irq_o, r.exp_irq, i);
      check_pins(gpio_out_o, r.exp_out, "gpio_out_o", i);
      check_pins(gpio_oe_o, r.exp_oe, "gpio_oe_o", i);
      $display("row %0d addr %h: %s", i, r.addr, (errors == row_err) ? "pass" : "fail");
    end
    errors += dut0.u_asserts.fail_cnt;
    $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule
